/* hw/playfield_pkg.sv */
// screen geometry, coordinate widths, sentinels and mode codes shared by the obstacle field
`default_nettype none

package playfield_pkg;

    // ====================
    // screen and play area
    // ====================
    localparam int screen_width = 640;
    localparam int upper_bound  = 20;
    localparam int lower_bound  = 460;

    // coordinate widths
    localparam int x_bits = 10;
    localparam int y_bits = 9;

    // shown by a slot that is not on screen
    localparam logic [x_bits-1:0] x_offscreen = x_bits'(700);
    localparam logic [y_bits-1:0] y_offscreen = y_bits'(500);

    // ====================
    // score
    // ====================
    localparam int score_bits = 14;
    localparam logic [score_bits-1:0] score_max = score_bits'(9999);

    // ====================
    // game mode codes
    // ====================
    // any value other than these two is a pause
    localparam logic [1:0] mode_idle = 2'd0;
    localparam logic [1:0] mode_run  = 2'd1;

endpackage

`default_nettype wire

/* hw/spawn_pkg.sv */
// random word layout, LFSR constants and obstacle size ranges used when spawning
`default_nettype none

package spawn_pkg;

    // ====================
    // random word
    // ====================
    // one 32-bit LFSR word, read either as four size bytes or with
    // the top byte split into an edge zone select and an edge offset
    typedef union packed {
        struct packed {
            logic [7:0] placement;
            logic [7:0] gap;
            logic [7:0] height;
            logic [7:0] width;
        } byte_view;
        struct packed {
            logic [1:0]  zone;
            logic [5:0]  offset;
            logic [23:0] size_bytes;
        } edge_view;
    } spawn_rand_u;

    // zone select values, 2 and 3 both mean middle
    localparam logic [1:0] zone_upper = 2'd0;
    localparam logic [1:0] zone_lower = 2'd1;

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_seed = 32'h1d87_2b41;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    // ====================
    // size and gap ranges
    // ====================
    localparam int min_width  = 20;
    localparam int max_width  = 80;
    localparam int min_height = 20;
    localparam int max_height = 150;
    localparam int min_gap    = 80;
    localparam int max_gap    = 180;
    localparam int gap_bits   = 8;

    // depth of the upper and lower edge zones in pixels
    localparam int edge_zone = 60;

endpackage

`default_nettype wire

/* hw/spawn_rng.sv */
// free-running LFSR, hands the spawn shaper a fresh random word every frame
`default_nettype none

module spawn_rng (
    input  logic                   clk,
    input  logic                   rst_n,
    output spawn_pkg::spawn_rand_u rand_word
);

    logic [31:0] lfsr;
    logic        feedback;

    // fibonacci form, xor of all tapped bits
    assign feedback = ^(lfsr & spawn_pkg::lfsr_taps);

    // steps in every mode, so idle time also stirs the sequence
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= spawn_pkg::lfsr_seed;
        end else begin
            lfsr <= {lfsr[30:0], feedback};
        end
    end

    assign rand_word = lfsr;

endmodule

`default_nettype wire

/* hw/spawn_shaper.sv */
// turns one random word into obstacle width, height, top edge and following gap
`default_nettype none

module spawn_shaper (
    input  spawn_pkg::spawn_rand_u                  rand_word,
    output logic [6:0]                              width,
    output logic [7:0]                              height,
    output logic [playfield_pkg::y_bits-1:0]        top,
    output logic [spawn_pkg::gap_bits-1:0]          gap
);

    localparam int y_w = playfield_pkg::y_bits;
    localparam int g_w = spawn_pkg::gap_bits;

    // number of values in each range, bounds included
    localparam int width_span  = spawn_pkg::max_width - spawn_pkg::min_width + 1;
    localparam int height_span = spawn_pkg::max_height - spawn_pkg::min_height + 1;
    localparam int gap_span    = spawn_pkg::max_gap - spawn_pkg::min_gap + 1;

    localparam logic [y_w-1:0] top_min = y_w'(playfield_pkg::upper_bound);
    localparam logic [y_w-1:0] floor_y = y_w'(playfield_pkg::lower_bound);

    logic [y_w-1:0] max_top;
    logic [y_w-1:0] span;
    logic [y_w-1:0] edge_off;
    logic [y_w-1:0] top_raw;

    // ====================
    // sizes and gap
    // ====================
    assign width  = 7'(spawn_pkg::min_width)
                  + 7'(rand_word.byte_view.width % 8'(width_span));
    assign height = 8'(spawn_pkg::min_height)
                  + (rand_word.byte_view.height % 8'(height_span));
    assign gap    = g_w'(spawn_pkg::min_gap)
                  + g_w'(rand_word.byte_view.gap % 8'(gap_span));

    // ====================
    // vertical placement
    // ====================
    always_comb begin
        // lowest top that keeps the bottom inside the play area
        max_top  = floor_y - y_w'(height);
        span     = max_top - top_min;
        edge_off = y_w'(rand_word.edge_view.offset % 6'(spawn_pkg::edge_zone));

        case (rand_word.edge_view.zone)
            spawn_pkg::zone_upper: begin
                top_raw = top_min + edge_off;
            end
            spawn_pkg::zone_lower: begin
                top_raw = max_top - edge_off;
            end
            default: begin
                // middle, whole placement byte as offset
                top_raw = top_min + (y_w'(rand_word.byte_view.placement) % span);
            end
        endcase

        // keep it between the play area edges
        if (top_raw < top_min) begin
            top = top_min;
        end else if (top_raw > max_top) begin
            top = max_top;
        end else begin
            top = top_raw;
        end
    end

endmodule

`default_nettype wire

/* hw/obstacle_slots.sv */
// obstacle slot store: scrolls, retires and loads slots, and encodes each bounding box
`default_nettype none

module obstacle_slots #(
    parameter int NUM_OBSTACLES = 10,
    parameter int SCROLL_SPEED  = 4
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   clear,
    input  logic                                                   advance,
    input  logic                                                   spawn_en,
    input  logic [$clog2(NUM_OBSTACLES)-1:0]                       spawn_slot,
    input  logic [6:0]                                             width,
    input  logic [7:0]                                             height,
    input  logic [playfield_pkg::y_bits-1:0]                       top,
    output logic [NUM_OBSTACLES-1:0]                               free_mask,
    output logic [$clog2(NUM_OBSTACLES):0]                         retire_count,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0]    box_left,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0]    box_right,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0]    box_top,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0]    box_bottom
);

    localparam int x_w = playfield_pkg::x_bits;
    localparam int y_w = playfield_pkg::y_bits;

    localparam logic [x_w-1:0] right_edge = x_w'(playfield_pkg::screen_width);
    localparam logic [x_w-1:0] step       = x_w'(SCROLL_SPEED);

    logic [NUM_OBSTACLES-1:0] active;
    logic [NUM_OBSTACLES-1:0] retiring;
    logic [x_w-1:0]           pos_x   [NUM_OBSTACLES];
    logic [y_w-1:0]           pos_top [NUM_OBSTACLES];
    logic [6:0]               obs_w   [NUM_OBSTACLES];
    logic [7:0]               obs_h   [NUM_OBSTACLES];

    // ====================
    // retirement
    // ====================
    // a slot leaves once another step would take x below zero
    always_comb begin
        retire_count = '0;
        for (int i = 0; i < NUM_OBSTACLES; i++) begin
            retiring[i] = advance && active[i] && (pos_x[i] < step);
            if (retiring[i]) begin
                retire_count = retire_count + 1'b1;
            end
        end
    end

    assign free_mask = ~active;

    // ====================
    // slot state
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= '0;
        end else if (clear) begin
            active <= '0;
        end else if (advance) begin
            for (int i = 0; i < NUM_OBSTACLES; i++) begin
                if (spawn_en && (spawn_slot == i)) begin
                    active[i] <= 1'b1;
                end else if (retiring[i]) begin
                    active[i] <= 1'b0;
                end
            end
        end
    end

    // position and size only matter while the slot is active
    always_ff @(posedge clk) begin
        if (advance && !clear) begin
            for (int i = 0; i < NUM_OBSTACLES; i++) begin
                if (spawn_en && (spawn_slot == i)) begin
                    pos_x[i]   <= right_edge;
                    pos_top[i] <= top;
                    obs_w[i]   <= width;
                    obs_h[i]   <= height;
                end else if (active[i] && !retiring[i]) begin
                    pos_x[i] <= pos_x[i] - step;
                end
            end
        end
    end

    // ====================
    // bounding boxes
    // ====================
    always_comb begin
        for (int i = 0; i < NUM_OBSTACLES; i++) begin
            if (active[i] && (pos_x[i] < right_edge)) begin
                box_left[i]   = pos_x[i];
                box_right[i]  = pos_x[i] + x_w'(obs_w[i]);
                box_top[i]    = pos_top[i];
                box_bottom[i] = pos_top[i] + y_w'(obs_h[i]);
            end else begin
                box_left[i]   = playfield_pkg::x_offscreen;
                box_right[i]  = playfield_pkg::x_offscreen;
                box_top[i]    = playfield_pkg::y_offscreen;
                box_bottom[i] = playfield_pkg::y_offscreen;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/obstacle_ctrl.sv */
// obstacle field controller that decodes the mode, paces spawns and keeps the score for the top level
`default_nettype none

module obstacle_ctrl #(
    parameter int NUM_OBSTACLES = 10,
    parameter int SCROLL_SPEED  = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [1:0]                             gamemode,
    input  logic [NUM_OBSTACLES-1:0]               free_mask,
    input  logic [$clog2(NUM_OBSTACLES):0]         retire_count,
    input  logic [spawn_pkg::gap_bits-1:0]         gap,
    output logic                                   clear,
    output logic                                   advance,
    output logic                                   spawn_en,
    output logic [$clog2(NUM_OBSTACLES)-1:0]       spawn_slot,
    output logic [playfield_pkg::score_bits-1:0]   score
);

    localparam int idx_bits = $clog2(NUM_OBSTACLES);
    localparam int cnt_w    = 12;
    localparam int sum_w    = playfield_pkg::score_bits + 1;

    localparam logic signed [cnt_w-1:0] spawn_line = cnt_w'(playfield_pkg::screen_width);
    localparam logic signed [cnt_w-1:0] first_gap  =
        cnt_w'(playfield_pkg::screen_width + spawn_pkg::min_gap);
    localparam logic signed [cnt_w-1:0] step = cnt_w'(SCROLL_SPEED);

    logic signed [cnt_w-1:0] countdown;
    logic [sum_w-1:0]        score_sum;

    // ====================
    // mode decode
    // ====================
    assign clear   = (gamemode == playfield_pkg::mode_idle);
    // no frame advances while reset is held
    assign advance = rst_n && (gamemode == playfield_pkg::mode_run);

    // lowest free slot wins
    always_comb begin
        spawn_slot = '0;
        for (int i = NUM_OBSTACLES - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                spawn_slot = idx_bits'(i);
            end
        end
    end

    // waits here while every slot is busy
    assign spawn_en = advance && (countdown <= spawn_line) && (|free_mask);

    // ====================
    // spawn countdown
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            countdown <= first_gap;
        end else if (clear) begin
            countdown <= first_gap;
        end else if (advance) begin
            if (spawn_en) begin
                countdown <= $signed(spawn_line + cnt_w'(gap));
            end else if (countdown >= 0) begin
                // stops once negative so a long wait cannot wrap it
                countdown <= countdown - step;
            end
        end
    end

    // ====================
    // score
    // ====================
    assign score_sum = {1'b0, score} + sum_w'(retire_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else if (clear) begin
            score <= '0;
        end else if (advance) begin
            if (score_sum > sum_w'(playfield_pkg::score_max)) begin
                score <= playfield_pkg::score_max;
            end else begin
                score <= score_sum[playfield_pkg::score_bits-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/obstacle_field.sv */
// top of the scrolling obstacle field, one clock per video frame
`default_nettype none

module obstacle_field #(
    parameter int NUM_OBSTACLES = 10,
    parameter int SCROLL_SPEED  = 4
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [1:0]                                             gamemode,
    output logic [playfield_pkg::score_bits-1:0]                   score,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0]    box_left,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0]    box_right,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0]    box_top,
    output logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0]    box_bottom
);

    spawn_pkg::spawn_rand_u                rand_word;
    logic [6:0]                            width;
    logic [7:0]                            height;
    logic [playfield_pkg::y_bits-1:0]      top;
    logic [spawn_pkg::gap_bits-1:0]        gap;
    logic                                  clear;
    logic                                  advance;
    logic                                  spawn_en;
    logic [$clog2(NUM_OBSTACLES)-1:0]      spawn_slot;
    logic [NUM_OBSTACLES-1:0]              free_mask;
    logic [$clog2(NUM_OBSTACLES):0]        retire_count;

    // ====================
    // spawn source
    // ====================
    spawn_rng spawn_rng_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rand_word (rand_word)
    );

    spawn_shaper spawn_shaper_inst (
        .rand_word (rand_word),
        .width     (width),
        .height    (height),
        .top       (top),
        .gap       (gap)
    );

    // ====================
    // control and slots
    // ====================
    obstacle_ctrl #(
        .NUM_OBSTACLES (NUM_OBSTACLES),
        .SCROLL_SPEED  (SCROLL_SPEED)
    ) obstacle_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .gamemode     (gamemode),
        .free_mask    (free_mask),
        .retire_count (retire_count),
        .gap          (gap),
        .clear        (clear),
        .advance      (advance),
        .spawn_en     (spawn_en),
        .spawn_slot   (spawn_slot),
        .score        (score)
    );

    obstacle_slots #(
        .NUM_OBSTACLES (NUM_OBSTACLES),
        .SCROLL_SPEED  (SCROLL_SPEED)
    ) obstacle_slots_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .advance      (advance),
        .spawn_en     (spawn_en),
        .spawn_slot   (spawn_slot),
        .width        (width),
        .height       (height),
        .top          (top),
        .free_mask    (free_mask),
        .retire_count (retire_count),
        .box_left     (box_left),
        .box_right    (box_right),
        .box_top      (box_top),
        .box_bottom   (box_bottom)
    );

endmodule

`default_nettype wire

/* verification/obstacle_field_assert.sv */
// concurrent checks on the obstacle slot store, bound into obstacle_slots for simulation
`default_nettype none

module obstacle_field_assert #(
    parameter int NUM_OBSTACLES = 10
) (
    input logic                                                clk,
    input logic                                                rst_n,
    input logic                                                spawn_en,
    input logic [$clog2(NUM_OBSTACLES)-1:0]                    spawn_slot,
    input logic [NUM_OBSTACLES-1:0]                            free_mask,
    input logic [$clog2(NUM_OBSTACLES):0]                      retire_count,
    input logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0] box_left,
    input logic [NUM_OBSTACLES-1:0][playfield_pkg::x_bits-1:0] box_right,
    input logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0] box_top,
    input logic [NUM_OBSTACLES-1:0][playfield_pkg::y_bits-1:0] box_bottom
);

    localparam int x_w = playfield_pkg::x_bits;

    // ====================
    // slot allocation
    // ====================
    spawn_free_a: assert property (@(posedge clk) disable iff (!rst_n)
        spawn_en |-> free_mask[spawn_slot])
        else $error("spawn loaded slot %0d while it was busy", spawn_slot);

    // only active slots can retire
    retire_count_a: assert property (@(posedge clk) disable iff (!rst_n)
        int'(retire_count) <= $countones(~free_mask))
        else $error("retire count %0d exceeds the active slots", retire_count);

    // ====================
    // box shape
    // ====================
    for (genvar i = 0; i < NUM_OBSTACLES; i++) begin : g_box
        box_order_a: assert property (@(posedge clk) disable iff (!rst_n)
            (box_left[i] < x_w'(playfield_pkg::screen_width)) |->
            ((box_right[i] > box_left[i]) && (box_bottom[i] > box_top[i])))
            else $error("slot %0d shows an inverted box", i);
    end

endmodule

bind obstacle_slots obstacle_field_assert #(
    .NUM_OBSTACLES (NUM_OBSTACLES)
) obstacle_field_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .spawn_en     (spawn_en),
    .spawn_slot   (spawn_slot),
    .free_mask    (free_mask),
    .retire_count (retire_count),
    .box_left     (box_left),
    .box_right    (box_right),
    .box_top      (box_top),
    .box_bottom   (box_bottom)
);

`default_nettype wire

/* verification/obstacle_field_tb.sv */
// testbench for the obstacle field, drives run, pause and idle and checks every frame
`default_nettype none

module obstacle_field_tb;

    localparam int n_obs  = 10;
    localparam int scroll = 4;
    localparam int x_w    = playfield_pkg::x_bits;
    localparam int y_w    = playfield_pkg::y_bits;
    localparam int s_w    = playfield_pkg::score_bits;
    localparam int x_off  = int'(playfield_pkg::x_offscreen);
    localparam int y_off  = int'(playfield_pkg::y_offscreen);

    // ====================
    // run length
    // ====================
    localparam int reset_cycles = 3;
    localparam int num_segments = 6;
    localparam int run_base     = 200;
    localparam int run_spread   = 100;
    localparam int pause_base   = 2;
    localparam int pause_spread = 10;
    localparam int idle_cycles  = 40;
    localparam int second_run   = 1000;
    localparam int test_cycles  = reset_cycles
        + num_segments * (run_base + run_spread + pause_base + pause_spread)
        + idle_cycles + second_run;
    // rounded up to a thousand, plus two thousand spare
    localparam int timeout_cycles = ((test_cycles + 999) / 1000 + 2) * 1000;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [1:0]                gamemode;
    logic [s_w-1:0]            score;
    logic [n_obs-1:0][x_w-1:0] box_left;
    logic [n_obs-1:0][x_w-1:0] box_right;
    logic [n_obs-1:0][y_w-1:0] box_top;
    logic [n_obs-1:0][y_w-1:0] box_bottom;

    // mode and reset as seen by the last rising edge
    logic [1:0]                edge_mode = playfield_pkg::mode_idle;
    logic                      edge_rst  = 1'b0;

    // outputs after the previous edge
    logic [n_obs-1:0][x_w-1:0] prev_left;
    logic [n_obs-1:0][x_w-1:0] prev_right;
    logic [n_obs-1:0][y_w-1:0] prev_top;
    logic [n_obs-1:0][y_w-1:0] prev_bottom;
    logic [s_w-1:0]            prev_score;

    // reference model results
    logic [n_obs-1:0][x_w-1:0] exp_left;
    logic [n_obs-1:0][x_w-1:0] exp_right;
    logic [n_obs-1:0][y_w-1:0] exp_top;
    logic [n_obs-1:0][y_w-1:0] exp_bottom;
    logic [n_obs-1:0]          may_appear;
    logic [s_w-1:0]            exp_score;

    int mismatch_count = 0;
    int failure_count  = 0;
    int cycle_count    = 0;
    bit seen_upper     = 1'b0;
    bit seen_lower     = 1'b0;
    bit seen_retire    = 1'b0;

    always #2 clk = ~clk;

    obstacle_field #(
        .NUM_OBSTACLES (n_obs),
        .SCROLL_SPEED  (scroll)
    ) obstacle_field_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gamemode   (gamemode),
        .score      (score),
        .box_left   (box_left),
        .box_right  (box_right),
        .box_top    (box_top),
        .box_bottom (box_bottom)
    );

    // ====================
    // reference model
    // ====================
    // one frame ahead; a hidden slot in run may show up at the spawn column
    function automatic logic [s_w-1:0] predict_frame(
        input  logic [1:0]                mode,
        input  logic [n_obs-1:0][x_w-1:0] left_in,
        input  logic [n_obs-1:0][x_w-1:0] right_in,
        input  logic [n_obs-1:0][y_w-1:0] top_in,
        input  logic [n_obs-1:0][y_w-1:0] bottom_in,
        input  logic [s_w-1:0]            score_in,
        output logic [n_obs-1:0][x_w-1:0] left_out,
        output logic [n_obs-1:0][x_w-1:0] right_out,
        output logic [n_obs-1:0][y_w-1:0] top_out,
        output logic [n_obs-1:0][y_w-1:0] bottom_out,
        output logic [n_obs-1:0]          appear
    );
        int retired;
        int total;
        retired    = 0;
        left_out   = left_in;
        right_out  = right_in;
        top_out    = top_in;
        bottom_out = bottom_in;
        appear     = '0;
        if (mode == playfield_pkg::mode_idle) begin
            for (int i = 0; i < n_obs; i++) begin
                left_out[i]   = x_w'(x_off);
                right_out[i]  = x_w'(x_off);
                top_out[i]    = y_w'(y_off);
                bottom_out[i] = y_w'(y_off);
            end
            return '0;
        end
        if (mode != playfield_pkg::mode_run) begin
            return score_in;
        end
        for (int i = 0; i < n_obs; i++) begin
            if (int'(left_in[i]) == x_off) begin
                appear[i] = 1'b1;
            end else if (int'(left_in[i]) < scroll) begin
                left_out[i]   = x_w'(x_off);
                right_out[i]  = x_w'(x_off);
                top_out[i]    = y_w'(y_off);
                bottom_out[i] = y_w'(y_off);
                retired++;
            end else begin
                left_out[i]  = left_in[i] - x_w'(scroll);
                right_out[i] = right_in[i] - x_w'(scroll);
            end
        end
        total = int'(score_in) + retired;
        if (total > int'(playfield_pkg::score_max)) begin
            total = int'(playfield_pkg::score_max);
        end
        return s_w'(total);
    endfunction

    // ====================
    // checks
    // ====================
    task automatic compare_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Mismatch at time %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic compare_box(input int slot, input int l, input int r, input int t,
                               input int b);
        compare_value($sformatf("box_left[%0d]", slot), int'(box_left[slot]), l);
        compare_value($sformatf("box_right[%0d]", slot), int'(box_right[slot]), r);
        compare_value($sformatf("box_top[%0d]", slot), int'(box_top[slot]), t);
        compare_value($sformatf("box_bottom[%0d]", slot), int'(box_bottom[slot]), b);
    endtask

    task automatic check_geometry(input int slot);
        int w;
        int h;
        w = int'(box_right[slot]) - int'(box_left[slot]);
        h = int'(box_bottom[slot]) - int'(box_top[slot]);
        if (w < spawn_pkg::min_width || w > spawn_pkg::max_width) begin
            report_failure($sformatf("slot %0d has width %0d outside its range", slot, w));
        end
        if (h < spawn_pkg::min_height || h > spawn_pkg::max_height) begin
            report_failure($sformatf("slot %0d has height %0d outside its range", slot, h));
        end
        if (int'(box_top[slot]) < playfield_pkg::upper_bound) begin
            report_failure($sformatf("slot %0d reaches above the play area", slot));
        end
        if (int'(box_bottom[slot]) > playfield_pkg::lower_bound) begin
            report_failure($sformatf("slot %0d reaches below the play area", slot));
        end
        if (int'(box_top[slot]) - playfield_pkg::upper_bound < spawn_pkg::edge_zone) begin
            seen_upper = 1'b1;
        end
        if (playfield_pkg::lower_bound - int'(box_bottom[slot]) < spawn_pkg::edge_zone) begin
            seen_lower = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        edge_mode <= gamemode;
        edge_rst  <= rst_n;
    end

    // outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (!edge_rst) begin
            compare_value("score", int'(score), 0);
            for (int i = 0; i < n_obs; i++) begin
                compare_box(i, x_off, x_off, y_off, y_off);
            end
        end else begin
            exp_score = predict_frame(edge_mode, prev_left, prev_right, prev_top, prev_bottom,
                                      prev_score, exp_left, exp_right, exp_top, exp_bottom,
                                      may_appear);
            compare_value("score", int'(score), int'(exp_score));
            for (int i = 0; i < n_obs; i++) begin
                if (may_appear[i] && int'(box_left[i]) != x_off) begin
                    compare_value($sformatf("box_left[%0d]", i), int'(box_left[i]),
                                  playfield_pkg::screen_width - scroll);
                end else begin
                    compare_box(i, int'(exp_left[i]), int'(exp_right[i]),
                                int'(exp_top[i]), int'(exp_bottom[i]));
                end
            end
            if (score > prev_score) begin
                seen_retire = 1'b1;
            end
        end
        for (int i = 0; i < n_obs; i++) begin
            if (int'(box_left[i]) < playfield_pkg::screen_width) begin
                check_geometry(i);
            end
        end
        prev_left   = box_left;
        prev_right  = box_right;
        prev_top    = box_top;
        prev_bottom = box_bottom;
        prev_score  = score;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ====================
    // stimulus
    // ====================
    task automatic hold_mode(input logic [1:0] mode, input int frames);
        gamemode = mode;
        repeat (frames) @(negedge clk);
    endtask

    initial begin
        logic [1:0] pause_mode;
        void'($urandom(32'heb81_3fef));
        rst_n    = 1'b0;
        gamemode = playfield_pkg::mode_run;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        // long run broken by short pauses at random points
        for (int s = 0; s < num_segments; s++) begin
            hold_mode(playfield_pkg::mode_run, run_base + int'($urandom % run_spread));
            pause_mode = ($urandom % 2 == 0) ? 2'd2 : 2'd3;
            hold_mode(pause_mode, pause_base + int'($urandom % pause_spread));
        end
        hold_mode(playfield_pkg::mode_idle, idle_cycles);
        hold_mode(playfield_pkg::mode_run, second_run);
        // last edge still needs its compare
        repeat (2) @(posedge clk);
        if (!seen_upper) begin
            report_failure("no box was seen near the upper edge of the play area");
        end
        if (!seen_lower) begin
            report_failure("no box was seen near the lower edge of the play area");
        end
        if (!seen_retire) begin
            report_failure("the score never rose during the run");
        end
        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/playfield_pkg.sv
hw/spawn_pkg.sv
hw/spawn_rng.sv
hw/spawn_shaper.sv
hw/obstacle_slots.sv
hw/obstacle_ctrl.sv
hw/obstacle_field.sv
verification/obstacle_field_assert.sv
verification/obstacle_field_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the obstacle field testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module obstacle_field_tb \
    -f sources.f -o obstacle_field_sim

./obj_dir/obstacle_field_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
